// File: Bender.yml
package:
  name: xfer_engine

sources:
  - common/xfer_pkg.sv
  - common/wb_if.sv
  - xfer/region_table.sv
  - xfer/xfer_ctrl.sv
  - xfer/burst_engine.sv
  - rtl/mem_arbiter.sv
  - rtl/word_mem.sv
  - rtl/xfer_top.sv
  - target: test
    files:
      - tests/tb_xfer_top.sv

// File: common/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic bus moving one word per access
interface wb_if import xfer_pkg::*; ();

    logic      cyc;
    logic      stb;
    logic      we;
    mem_addr_t adr;
    word_t     dat_w;
    word_t     dat_r;
    logic      ack;     // single cycle

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

// File: common/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

    // ==================================================
    // data path types
    // ==================================================
    typedef logic [127:0] word_t;
    typedef logic [9:0]   mem_addr_t;
    typedef logic [3:0]   ifcode_t;
    typedef logic [5:0]   xfer_len_t;   // up to 32 beats

    localparam int MEM_WORDS  = 1024;
    localparam int CODE_LSB   = 18;     // code field in the request word
    localparam int NUM_CODES  = 8;
    localparam int CODE_IDX_W = $clog2(NUM_CODES);

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

    // ==================================================
    // interface codes
    // ==================================================
    localparam ifcode_t CODE_CFG     = 4'd0;
    localparam ifcode_t CODE_FLGOFM  = 4'd1;
    localparam ifcode_t CODE_OFM     = 4'd2;
    localparam ifcode_t CODE_WEIADDR = 4'd3;
    localparam ifcode_t CODE_WEI     = 4'd4;
    localparam ifcode_t CODE_FLGWEI  = 4'd5;
    localparam ifcode_t CODE_ACT     = 4'd6;
    localparam ifcode_t CODE_FLGACT  = 4'd7;

    function automatic logic code_valid(input ifcode_t code);
        return code inside {CODE_CFG, CODE_WEIADDR, CODE_FLGWEI, CODE_WEI,
                            CODE_FLGACT, CODE_ACT, CODE_OFM, CODE_FLGOFM};
    endfunction

    // output maps flow chip to memory
    function automatic logic code_is_write(input ifcode_t code);
        return (code == CODE_OFM) || (code == CODE_FLGOFM);
    endfunction

    function automatic xfer_len_t code_len(input ifcode_t code);
        case (code)
            CODE_CFG, CODE_WEIADDR, CODE_OFM, CODE_FLGOFM:  return xfer_len_t'(8);
            CODE_FLGWEI, CODE_WEI, CODE_FLGACT, CODE_ACT:   return xfer_len_t'(32);
            default:                                        return '0;
        endcase
    endfunction

    // transfers per region before the pointer wraps
    function automatic mem_addr_t code_blocks(input ifcode_t code);
        case (code)
            CODE_FLGWEI:                                    return mem_addr_t'(1);
            CODE_WEIADDR, CODE_WEI:                         return mem_addr_t'(2);
            CODE_ACT:                                       return mem_addr_t'(9);
            CODE_CFG, CODE_FLGACT, CODE_OFM, CODE_FLGOFM:   return mem_addr_t'(4);
            default:                                        return '0;
        endcase
    endfunction

    function automatic mem_addr_t code_base(input ifcode_t code);
        case (code)
            CODE_CFG:     return mem_addr_t'(0);
            CODE_WEIADDR: return mem_addr_t'(32);
            CODE_FLGWEI:  return mem_addr_t'(48);
            CODE_WEI:     return mem_addr_t'(80);
            CODE_FLGACT:  return mem_addr_t'(144);
            CODE_ACT:     return mem_addr_t'(272);
            CODE_OFM:     return mem_addr_t'(560);
            CODE_FLGOFM:  return mem_addr_t'(592);
            default:      return '0;
        endcase
    endfunction

    // first address past the region
    function automatic mem_addr_t code_region_end(input ifcode_t code);
        return code_base(code) + mem_addr_t'(code_len(code)) * code_blocks(code);
    endfunction

endpackage

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  host,
    wb_if.slave  eng,
    wb_if.master mem
);

    logic locked;       // an access is in flight
    logic owner_eng;
    logic last_eng;     // engine got the last ack
    logic sel_eng;

    // ==================================================
    // grant
    // ==================================================
    always_comb begin
        if (locked) begin
            sel_eng = owner_eng;
        end else if (host.cyc && eng.cyc) begin
            sel_eng = !last_eng;    // alternate under contention
        end else begin
            sel_eng = eng.cyc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            owner_eng <= 1'b0;
            last_eng  <= 1'b0;
        end else begin
            locked    <= mem.cyc && !mem.ack;   // free again after the ack
            owner_eng <= sel_eng;
            if (mem.ack) begin
                last_eng <= sel_eng;
            end
        end
    end

    // ==================================================
    // routing
    // ==================================================
    assign mem.cyc   = sel_eng ? eng.cyc   : host.cyc;
    assign mem.stb   = sel_eng ? eng.stb   : host.stb;
    assign mem.we    = sel_eng ? eng.we    : host.we;
    assign mem.adr   = sel_eng ? eng.adr   : host.adr;
    assign mem.dat_w = sel_eng ? eng.dat_w : host.dat_w;

    assign host.ack   = mem.ack && !sel_eng;
    assign eng.ack    = mem.ack && sel_eng;
    assign host.dat_r = sel_eng ? '0 : mem.dat_r;
    assign eng.dat_r  = sel_eng ? mem.dat_r : '0;

endmodule

`default_nettype wire

// File: rtl/word_mem.sv
`timescale 1ns/1ps
`default_nettype none

module word_mem import xfer_pkg::*; (
    input  logic clk,
    wb_if.slave  bus
);

    word_t mem_q [MEM_WORDS];
    logic  access;

    // only the first cycle of a strobe since ack masks the rest
    assign access = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk) begin
        bus.ack <= access;
        if (access) begin
            if (bus.we) begin
                mem_q[bus.adr] <= bus.dat_w;
            end
            bus.dat_r <= mem_q[bus.adr];    // old word on a write
        end
    end

endmodule

`default_nettype wire

// File: rtl/xfer_top.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_top import xfer_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // host port, wishbone classic
    input  logic      host_cyc,
    input  logic      host_stb,
    input  logic      host_we,
    input  mem_addr_t host_adr,
    input  word_t     host_dat_w,
    output word_t     host_dat_r,
    output logic      host_ack,

    // chip data port
    input  logic      config_req,
    input  word_t     data_in,
    output word_t     data_out,
    output logic      data_oe,
    output logic      cs_n
);

    logic      start;
    logic      write;
    mem_addr_t base;
    xfer_len_t length;
    logic      ready;
    logic      beat;
    word_t     rd_word;
    word_t     wr_word;
    logic      busy;

    wb_if host_bus ();
    wb_if eng_bus ();
    wb_if mem_bus ();

    // ==================================================
    // host bundle
    // ==================================================
    assign host_bus.cyc   = host_cyc;
    assign host_bus.stb   = host_stb;
    assign host_bus.we    = host_we;
    assign host_bus.adr   = host_adr;
    assign host_bus.dat_w = host_dat_w;
    assign host_dat_r     = host_bus.dat_r;
    assign host_ack       = host_bus.ack;

    xfer_ctrl i_xfer_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_req (config_req),
        .data_in    (data_in),
        .data_out   (data_out),
        .data_oe    (data_oe),
        .cs_n       (cs_n),
        .start      (start),
        .write      (write),
        .base       (base),
        .length     (length),
        .ready      (ready),
        .beat       (beat),
        .rd_word    (rd_word),
        .wr_word    (wr_word),
        .busy       (busy)
    );

    burst_engine i_burst_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .write   (write),
        .base    (base),
        .length  (length),
        .ready   (ready),
        .beat    (beat),
        .rd_word (rd_word),
        .wr_word (wr_word),
        .busy    (busy),
        .bus     (eng_bus)
    );

    mem_arbiter i_mem_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .host  (host_bus),
        .eng   (eng_bus),
        .mem   (mem_bus)
    );

    word_mem i_word_mem (
        .clk (clk),
        .bus (mem_bus)
    );

endmodule

`default_nettype wire

// File: tests/tb_xfer_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xfer_top import xfer_pkg::*;;

    localparam int N_XFERS = 62;    // random, wrap, write, contention, invalid
    localparam int N_HOST  = 748;   // random, preload, readback, contention
    localparam int TIMEOUT_CYC = N_XFERS * 400 + N_HOST * 20;
    localparam word_t ALL_ONES = '1;

    logic      clk;
    logic      rst_n;
    logic      host_cyc;
    logic      host_stb;
    logic      host_we;
    mem_addr_t host_adr;
    word_t     host_dat_w;
    word_t     host_dat_r;
    logic      host_ack;
    logic      config_req;
    word_t     data_in;
    word_t     data_out;
    logic      data_oe;
    logic      cs_n;

    word_t       model_mem [1024];
    int          model_ptr [8];
    logic [31:0] rng_state = 32'hc26f_89c3;
    int          errors = 0;
    int          n_xfer = 0;
    int          n_host = 0;
    int          read_codes [6] = '{0, 3, 5, 4, 7, 6};

    xfer_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // ==================================================
    // random numbers and code table
    // ==================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        for (int i = 0; i < 4; i++) w = {w[95:0], next_rand()};
        return w;
    endfunction

    function automatic int pick(input int n);
        return int'((next_rand() >> 8) % n);   // low lcg bits are weak
    endfunction

    function automatic int len_of(input int c);
        return (c inside {0, 1, 2, 3}) ? 8 : (c inside {4, 5, 6, 7}) ? 32 : 0;
    endfunction

    function automatic int blocks_of(input int c);
        case (c)
            5:       return 1;
            3, 4:    return 2;
            6:       return 9;
            default: return 4;
        endcase
    endfunction

    function automatic int base_of(input int c);
        case (c)
            0: return 0;
            3: return 32;
            5: return 48;
            4: return 80;
            7: return 144;
            6: return 272;
            2: return 560;
            default: return 592;
        endcase
    endfunction

    // ==================================================
    // host port
    // ==================================================
    task automatic host_access(input logic we, input mem_addr_t adr, input word_t wdat,
                               output word_t rdat);
        int acks;
        int cycles;
        @(posedge clk);
        #1;
        host_cyc   = 1'b1;
        host_stb   = 1'b1;
        host_we    = we;
        host_adr   = adr;
        host_dat_w = wdat;
        acks   = 0;
        cycles = 0;
        while (acks == 0 && cycles < 200) begin
            @(negedge clk);
            cycles++;
            if (host_ack) begin
                acks++;
                rdat = host_dat_r;
            end
        end
        @(posedge clk);
        #1;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
        @(negedge clk);
        if (host_ack) acks++;   // second ack would be a protocol error
        n_host++;
        assert (acks == 1) else begin
            errors++;
            $display("host access at address %h saw %0d acks instead of one", adr, acks);
        end
    endtask

    task automatic host_write(input mem_addr_t adr, input word_t dat);
        word_t unused;
        host_access(1'b1, adr, dat, unused);
        model_mem[adr] = dat;
    endtask

    task automatic host_read(input mem_addr_t adr);
        word_t got;
        host_access(1'b0, adr, '0, got);
        assert (got === model_mem[adr]) else begin
            errors++;
            $display("ERR host_dat_r adr %h: got %h exp %h", adr, got, model_mem[adr]);
        end
    endtask

    // ==================================================
    // chip port
    // ==================================================
    task automatic send_request(input int code);
        word_t req;
        req = rand_word();
        req[21:18] = code[3:0];
        @(posedge clk);
        #1;
        config_req = 1'b1;
        data_in    = req;
        @(posedge clk);
        #1;
        config_req = 1'b0;
    endtask

    task automatic run_transfer(input int code);
        word_t wdata [32];
        int    len;
        int    p;
        int    idx;
        int    cycles;
        logic  wr;
        len = len_of(code);
        p   = model_ptr[code];
        wr  = (code == 1) || (code == 2);
        for (int i = 0; i < 32; i++) wdata[i] = rand_word();
        send_request(code);
        data_in = wdata[0];
        idx     = 0;
        cycles  = 0;
        while (idx < len && cycles < 400) begin
            @(negedge clk);
            cycles++;
            if (wr) begin
                assert (data_oe === 1'b0) else begin
                    errors++;
                    $display("ERR data_oe code %0d: got %h exp %h", code, data_oe, 1'b0);
                end
            end
            // no read beat on this edge so the port idles high
            if (wr || cs_n !== 1'b0) begin
                assert (data_out === ALL_ONES) else begin
                    errors++;
                    $display("ERR data_out code %0d idle: got %h exp %h",
                             code, data_out, ALL_ONES);
                end
            end
            if (cs_n === 1'b0) begin
                if (wr) begin
                    model_mem[p + idx] = wdata[idx];    // captured at this edge
                end else begin
                    assert (data_out === model_mem[p + idx]) else begin
                        errors++;
                        $display("ERR data_out code %0d beat %0d: got %h exp %h",
                                 code, idx, data_out, model_mem[p + idx]);
                    end
                    assert (data_oe === 1'b1) else begin
                        errors++;
                        $display("ERR data_oe code %0d beat %0d: got %h exp %h",
                                 code, idx, data_oe, 1'b1);
                    end
                end
                idx++;
            end
            @(posedge clk);
            #1;
            if (idx < len) data_in = wdata[idx];
        end
        @(negedge clk);
        assert (cs_n === 1'b1) else begin
            errors++;
            $display("extra beat after the last word of code %0d", code);
        end
        // writes end when the engine has drained its FIFO
        while (wr && i_dut.busy && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        assert (idx == len && cycles < 400) else begin
            errors++;
            $display("transfer of code %0d stalled after %0d of %0d beats", code, idx, len);
        end
        @(posedge clk);
        #1;
        model_ptr[code] += len;
        if (model_ptr[code] >= base_of(code) + len * blocks_of(code))
            model_ptr[code] = base_of(code);
        n_xfer++;
    endtask

    task automatic send_bad_code(input int code);
        send_request(code);
        repeat (8) begin
            @(negedge clk);
            assert (cs_n === 1'b1 && data_oe === 1'b0) else begin
                errors++;
                $display("invalid code %0d started a transfer", code);
            end
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        mem_addr_t adrs [16];
        mem_addr_t a;
        word_t     w;
        int        c;
        int        dly;
        rst_n      = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        config_req = 1'b0;
        data_in    = '0;
        for (int i = 0; i < 8; i++) model_ptr[i] = base_of(i);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (3) begin
            @(negedge clk);
            assert (cs_n === 1'b1 && data_oe === 1'b0 && host_ack === 1'b0) else begin
                errors++;
                $display("ERR reset state: cs_n %h data_oe %h host_ack %h",
                         cs_n, data_oe, host_ack);
            end
        end

        for (int i = 0; i < 16; i++) begin
            adrs[i] = mem_addr_t'(624 + pick(400));   // outside every region
            host_write(adrs[i], rand_word());
        end
        for (int i = 0; i < 16; i++) host_read(adrs[i]);

        for (int i = 0; i < 624; i++) host_write(mem_addr_t'(i), rand_word());

        for (int i = 0; i < 12; i++) run_transfer(read_codes[pick(6)]);

        // walk each read region past its end
        for (int k = 0; k < 6; k++) begin
            repeat (blocks_of(read_codes[k]) + 1) run_transfer(read_codes[k]);
        end

        for (int n = 0; n < 5; n++) begin
            for (int k = 1; k <= 2; k++) begin
                a = mem_addr_t'(model_ptr[k]);
                run_transfer(k);
                for (int i = 0; i < 8; i++) host_read(a + mem_addr_t'(i));
            end
        end

        for (int i = 0; i < 6; i++) begin
            c   = read_codes[pick(6)];
            dly = pick(8);
            a   = mem_addr_t'(624 + pick(400));
            w   = rand_word();
            fork
                run_transfer(c);
                begin
                    repeat (dly + 3) @(posedge clk);
                    host_write(a, w);
                    host_read(a);
                end
            join
        end

        for (int i = 0; i < 3; i++) begin
            send_bad_code(8 + pick(8));
            run_transfer(read_codes[pick(6)]);
        end

        $display("transfers %0d, host accesses %0d, errors %0d", n_xfer, n_host, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/xfer_pkg.sv
common/wb_if.sv
xfer/region_table.sv
xfer/xfer_ctrl.sv
xfer/burst_engine.sv
rtl/mem_arbiter.sv
rtl/word_mem.sv
rtl/xfer_top.sv
tests/tb_xfer_top.sv

// File: xfer/burst_engine.sv
`timescale 1ns/1ps
`default_nettype none

module burst_engine import xfer_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      write,
    input  mem_addr_t base,
    input  xfer_len_t length,
    output logic      ready,
    input  logic      beat,
    output word_t     rd_word,
    input  word_t     wr_word,
    output logic      busy,
    wb_if.master      bus
);

    word_t                 fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    fifo_cnt_t             count;
    word_t                 head;
    logic                  wr_mode;
    logic                  cyc_q;
    mem_addr_t             adr_q;
    xfer_len_t             left;    // words not yet moved over the bus
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;
    logic                  issue;

    // ==================================================
    // word FIFO
    // ==================================================
    assign full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign head  = fifo_mem[rd_ptr];

    // reads fill from the bus, writes fill from the chip
    assign push = wr_mode ? beat : bus.ack;
    assign pop  = wr_mode ? bus.ack : beat;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= wr_mode ? wr_word : bus.dat_r;
        end
    end

    assign ready   = wr_mode ? !full : !empty;
    assign rd_word = head;
    assign busy    = (left != '0);

    // ==================================================
    // bus master
    // ==================================================
    // one access in flight, stb drops for a cycle after each ack
    assign issue = !cyc_q && busy && (wr_mode ? !empty : !full);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_mode <= 1'b0;
            cyc_q   <= 1'b0;
            adr_q   <= '0;
            left    <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            if (start) begin
                wr_mode <= write;
                adr_q   <= base;
                left    <= length;
                cyc_q   <= 1'b0;
            end else if (cyc_q) begin
                if (bus.ack) begin
                    cyc_q <= 1'b0;
                    adr_q <= adr_q + 10'd1;
                    left  <= left - 6'd1;
                end
            end else if (issue) begin
                cyc_q <= 1'b1;
            end

            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign bus.cyc   = cyc_q;
    assign bus.stb   = cyc_q;
    assign bus.we    = wr_mode;
    assign bus.adr   = adr_q;
    assign bus.dat_w = head;    // head is stable until the ack pops it

endmodule

`default_nettype wire

// File: xfer/region_table.sv
`timescale 1ns/1ps
`default_nettype none

module region_table import xfer_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ifcode_t   code,
    output mem_addr_t ptr,
    input  logic      advance
);

    mem_addr_t ptr_q [NUM_CODES];
    mem_addr_t cur_ptr;
    mem_addr_t next_ptr;
    logic      code_ok;

    assign code_ok = code_valid(code);
    assign cur_ptr = ptr_q[code[CODE_IDX_W-1:0]];
    assign ptr     = code_ok ? cur_ptr : '0;

    // ==================================================
    // advance with wrap
    // ==================================================
    always_comb begin
        next_ptr = cur_ptr + mem_addr_t'(code_len(code));
        if (next_ptr >= code_region_end(code)) begin
            next_ptr = code_base(code);     // region used up
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CODES; i++) begin
                ptr_q[i] <= code_base(ifcode_t'(i));
            end
        end else if (advance && code_ok) begin
            ptr_q[code[CODE_IDX_W-1:0]] <= next_ptr;
        end
    end

endmodule

`default_nettype wire

// File: xfer/xfer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_ctrl import xfer_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // chip side
    input  logic      config_req,
    input  word_t     data_in,
    output word_t     data_out,
    output logic      data_oe,
    output logic      cs_n,

    // engine side
    output logic      start,
    output logic      write,
    output mem_addr_t base,
    output xfer_len_t length,
    input  logic      ready,
    output logic      beat,
    input  word_t     rd_word,
    output word_t     wr_word,
    input  logic      busy
);

    typedef enum logic [2:0] {
        IDLE,
        CONFIG,
        WAIT0,
        WAIT1,
        DATA,
        FLUSH
    } state_t;

    state_t    state;
    state_t    next_state;
    ifcode_t   code_q;
    xfer_len_t beat_cnt;
    xfer_len_t len;
    mem_addr_t ptr;
    logic      code_ok;
    logic      is_write;
    logic      last_beat;
    logic      done;
    logic      oe_tail;     // keeps the pad driven one cycle past the last beat

    region_table i_region_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .code    (code_q),
        .ptr     (ptr),
        .advance (done)
    );

    // ==================================================
    // code lookup
    // ==================================================
    assign code_ok   = code_valid(code_q);
    assign is_write  = code_is_write(code_q);
    assign len       = code_len(code_q);
    assign last_beat = (beat_cnt == len - 6'd1);

    assign start  = (state == CONFIG) && code_ok;
    assign write  = is_write;
    assign base   = ptr;
    assign length = len;

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:   if (config_req) next_state = CONFIG;
            CONFIG: next_state = code_ok ? WAIT0 : IDLE;   // bad code gives no beats
            WAIT0:  next_state = WAIT1;
            WAIT1:  next_state = DATA;
            DATA: begin
                if (beat && last_beat) begin
                    next_state = is_write ? FLUSH : IDLE;
                end
            end
            FLUSH:  if (!busy) next_state = IDLE;          // last words still in the FIFO
            default: next_state = IDLE;
        endcase
    end

    // region pointer steps once per finished transfer
    assign done = ((state == DATA) && beat && last_beat && !is_write) ||
                  ((state == FLUSH) && !busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            code_q   <= '0;
            beat_cnt <= '0;
            oe_tail  <= 1'b0;
        end else begin
            state <= next_state;
            if ((state == IDLE) && config_req) begin
                code_q <= data_in[CODE_LSB +: $bits(ifcode_t)];
            end
            if (state == CONFIG) begin
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 6'd1;
            end
            oe_tail <= beat && last_beat && !is_write;
        end
    end

    // ==================================================
    // chip side framing
    // ==================================================
    assign beat     = (state == DATA) && ready;   // stall when the engine is not ready
    assign cs_n     = !beat;
    assign data_oe  = ((state == DATA) && !is_write) || oe_tail;
    assign data_out = (beat && !is_write) ? rd_word : '1;
    assign wr_word  = data_in;

endmodule

`default_nettype wire
